//--- Makefile
# Verilator build and run of the receive channel testbench

TOP = aib_rx_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > run.log 2>&1; cat run.log
	@if grep -q "RESULT: FAIL" run.log; then exit 1; fi
	@grep -q "RESULT: PASS" run.log

clean:
	rm -rf obj_dir run.log

//--- include/aib_rx_config.svh
// ====================
// Build-time sizes for the AIB receive channel
// The word must be a whole number of DBI lanes
// The FIFO depth must be a power of two, 4 or more
// ====================

`ifndef AIB_RX_CONFIG_SVH
`define AIB_RX_CONFIG_SVH

// One IO word from the buffer
`define AIB_RX_WORD_W 80

// DBI lane width, top bit of each lane is its inversion flag
`define AIB_RX_LANE_W 20

// Phase compensation FIFO entries
`define AIB_RX_FIFO_DEPTH 16

// Number of words in the widest group (FIFO_4X)
`define AIB_RX_GROUP_WORDS 4

// Word-mark bit, always the top bit of the word
`define AIB_RX_MARK_BIT (`AIB_RX_WORD_W - 1)

`endif

//--- rtl/aib_adapter_rxchnl.sv
// ====================
// AIB receive channel, DBI then align, FIFO, assemble
// data_out is the register-mode path, one write cycle after din
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_config.svh"

module aib_adapter_rxchnl
   import aib_rx_pkg::*;
(
   input  logic                      rxfifo_wrclk,  // Write clock
   input  logic                      rxfifo_rd_clk, // Read clock
   input  logic                      rst,           // Sync reset, write domain
   input  rx_cfg_t                   cfg,           // Channel config
   input  logic [`AIB_RX_WORD_W-1:0] din,           // Word from IO buffer
   output logic [`AIB_RX_WORD_W-1:0] data_out,      // Register mode output
   output rx_group_t                 rx_adapt_dout, // FIFO mode output
   output logic                      rx_fifo_valid, // Group done pulse
   output logic                      align_done,    // Word mark lock
   output logic                      fifo_overflow  // Dropped write, sticky
);

   rx_word_t wr_word;                               // Aligner to FIFO
   logic     wr_en;
   rx_word_t rd_word;                               // FIFO to assembler
   logic     rd_valid;
   logic     rst_rd;                                // Read-domain reset

   aib_rx_dbi rx_dbi (
      .rxfifo_wrclk (rxfifo_wrclk),
      .rst          (rst),
      .dbi_en       (cfg.dbi_en),
      .din          (din),
      .dbi_dout     (data_out)                      // Also feeds the aligner
   );

   aib_rx_word_align rx_word_align (
      .rxfifo_wrclk (rxfifo_wrclk),
      .rst          (rst),
      .cfg          (cfg),
      .dbi_dout     (data_out),
      .wr_word      (wr_word),
      .wr_en        (wr_en),
      .align_done   (align_done)
   );

   aib_rx_phcomp_fifo rx_phcomp_fifo (
      .rxfifo_wrclk  (rxfifo_wrclk),
      .rxfifo_rd_clk (rxfifo_rd_clk),
      .rst           (rst),
      .wr_word       (wr_word),
      .wr_en         (wr_en),
      .rd_delay      (cfg.rd_delay),
      .rd_word       (rd_word),
      .rd_valid      (rd_valid),
      .fifo_overflow (fifo_overflow),
      .rst_rd        (rst_rd)
   );

   aib_rx_rd_assemble rx_rd_assemble (
      .rxfifo_rd_clk (rxfifo_rd_clk),
      .rst_rd        (rst_rd),
      .cfg           (cfg),
      .rd_word       (rd_word),
      .rd_valid      (rd_valid),
      .rx_adapt_dout (rx_adapt_dout),
      .rx_fifo_valid (rx_fifo_valid)
   );

endmodule

`default_nettype wire

//--- rtl/aib_rx_dbi.sv
// ====================
// DBI decode, one register stage on the write clock
// A lane with its flag set is inverted below the flag
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_config.svh"

module aib_rx_dbi (
   input  logic                      rxfifo_wrclk,  // Write clock
   input  logic                      rst,           // Sync reset, active high
   input  logic                      dbi_en,        // Decode enable
   input  logic [`AIB_RX_WORD_W-1:0] din,           // Word from IO buffer
   output logic [`AIB_RX_WORD_W-1:0] dbi_dout       // Decoded word, registered
);

   localparam int LW    = `AIB_RX_LANE_W;
   localparam int LANES = `AIB_RX_WORD_W / `AIB_RX_LANE_W;

   logic [`AIB_RX_WORD_W-1:0] dec;                  // Decoded word, comb

   // Per-lane decode
   for (genvar g = 0; g < LANES; g++) begin : g_lane
      logic [LW-1:0] lane;                          // Raw lane slice
      logic          inv;                           // Lane needs inverting

      assign lane = din[g*LW +: LW];
      assign inv  = dbi_en & lane[LW-1];            // Flag is lane MSB

      // Flag cleared, payload bits flipped
      assign dec[g*LW +: LW] = inv ? {1'b0, ~lane[LW-2:0]} : lane;
   end

   // Output stage, one write cycle of latency
   always_ff @(posedge rxfifo_wrclk) begin
      if (rst) begin
         dbi_dout <= '0;
      end else begin
         dbi_dout <= dec;
      end
   end

endmodule

`default_nettype wire

//--- rtl/aib_rx_phcomp_fifo.sv
// ====================
// Phase compensation FIFO, write clock to read clock
// Reads start once the fill seen on the read side reaches rd_delay
// Writes into a full FIFO are dropped and flagged, sticky
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_config.svh"

module aib_rx_phcomp_fifo
   import aib_rx_pkg::*;
(
   input  logic     rxfifo_wrclk,                   // Write clock
   input  logic     rxfifo_rd_clk,                  // Read clock
   input  logic     rst,                            // Sync reset, write domain
   input  rx_word_t wr_word,                        // Write data
   input  logic     wr_en,                          // Write strobe
   input  logic [3:0] rd_delay,                     // Start fill level
   output rx_word_t rd_word,                        // Read data
   output logic     rd_valid,                       // One word this cycle
   output logic     fifo_overflow,                  // Dropped write, sticky
   output logic     rst_rd                          // Reset in read domain
);

   localparam int DEPTH = `AIB_RX_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);
   localparam int PW    = AW + 1;                   // Extra wrap bit

   function automatic logic [PW-1:0] bin2gray(input logic [PW-1:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [PW-1:0] gray2bin(input logic [PW-1:0] g);
      logic [PW-1:0] b;
      b[PW-1] = g[PW-1];
      for (int i = PW - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   rx_word_t      mem [DEPTH];                      // Storage, no reset

   logic [PW-1:0] wr_bin, wr_gray;                  // Write pointer
   logic [PW-1:0] rd_gray_w1, rd_gray_w2;           // Read ptr in write domain
   logic          full;

   logic [1:0]    rst_sync;                         // Reset synchronizer
   logic [PW-1:0] rd_bin, rd_gray;                  // Read pointer
   logic [PW-1:0] wr_gray_r1, wr_gray_r2;           // Write ptr in read domain
   logic [PW-1:0] fill;                             // Level seen by reader
   logic          empty;
   logic          rd_start;                         // Fill delay reached
   logic          rd_go;

   // Write domain
   assign full = (wr_gray == {~rd_gray_w2[PW-1:PW-2], rd_gray_w2[PW-3:0]});

   always_ff @(posedge rxfifo_wrclk) begin
      if (rst) begin
         wr_bin        <= '0;
         wr_gray       <= '0;
         rd_gray_w1    <= '0;
         rd_gray_w2    <= '0;
         fifo_overflow <= 1'b0;
      end else begin
         rd_gray_w1 <= rd_gray;
         rd_gray_w2 <= rd_gray_w1;
         if (wr_en && !full) begin
            wr_bin  <= wr_bin + 1'b1;
            wr_gray <= bin2gray(wr_bin + 1'b1);
         end
         if (wr_en && full) begin
            fifo_overflow <= 1'b1;                  // Word lost
         end
      end
   end

   always_ff @(posedge rxfifo_wrclk) begin
      if (wr_en && !full) begin
         mem[wr_bin[AW-1:0]] <= wr_word;
      end
   end

   // Read domain reset, two flops
   always_ff @(posedge rxfifo_rd_clk) begin
      rst_sync <= {rst_sync[0], rst};
   end

   assign rst_rd = rst_sync[1];

   assign fill  = gray2bin(wr_gray_r2) - rd_bin;
   assign empty = (wr_gray_r2 == rd_gray);
   assign rd_go = rd_start & ~empty;

   always_ff @(posedge rxfifo_rd_clk) begin
      if (rst_rd) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_r1 <= '0;
         wr_gray_r2 <= '0;
         rd_start   <= 1'b0;
         rd_valid   <= 1'b0;
      end else begin
         wr_gray_r1 <= wr_gray;
         wr_gray_r2 <= wr_gray_r1;
         if (fill >= PW'(rd_delay)) begin
            rd_start <= 1'b1;                       // Latched until reset
         end
         rd_valid <= rd_go;
         if (rd_go) begin
            rd_bin  <= rd_bin + 1'b1;
            rd_gray <= bin2gray(rd_bin + 1'b1);
         end
      end
   end

   // Read data register
   always_ff @(posedge rxfifo_rd_clk) begin
      if (rd_go) begin
         rd_word <= mem[rd_bin[AW-1:0]];
      end
   end

endmodule

`default_nettype wire

//--- rtl/aib_rx_pkg.sv
// ====================
// Types shared by the receive channel blocks
// Sizes come from the config header
// ====================

`default_nettype none

`include "aib_rx_config.svh"

package aib_rx_pkg;

   // FIFO mode register encoding
   typedef enum logic [1:0] {
      FIFO_1X  = 2'd0,                      // One word per group
      FIFO_2X  = 2'd1,                      // Two words per group
      FIFO_4X  = 2'd2,                      // Four words per group
      REG_MODE = 2'd3                       // FIFO path idle
   } rx_fifo_mode_e;

   // One word through the FIFO path
   typedef struct packed {
      logic [`AIB_RX_WORD_W-1:0] data;      // Decoded IO word
      logic                      first;     // First word of a group
   } rx_word_t;

   // Assembled group, slot k holds word k
   typedef logic [`AIB_RX_GROUP_WORDS-1:0][`AIB_RX_WORD_W-1:0] rx_group_t;

   // Static channel configuration
   typedef struct packed {
      rx_fifo_mode_e fifo_mode;             // Group size or register mode
      logic          wa_en;                 // Word-mark alignment enable
      logic          dbi_en;                // Data bus inversion enable
      logic          swap_en;               // Half-word swap, gen1 FIFO_2X
      logic          gen2_mode;             // Generation 2 link
      logic [4:0]    align_threshold;       // Good periods needed for lock
      logic [3:0]    rd_delay;              // Fill level before first read
   } rx_cfg_t;

endpackage

`default_nettype wire

//--- rtl/aib_rx_rd_assemble.sv
// ====================
// Packs 1, 2 or 4 words into the 320-bit FIFO output
// Words before the first tagged word are ignored
// Gen1 FIFO_2X may swap the halves of the low word
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_config.svh"

module aib_rx_rd_assemble
   import aib_rx_pkg::*;
(
   input  logic      rxfifo_rd_clk,                 // Read clock
   input  logic      rst_rd,                        // Read-domain reset
   input  rx_cfg_t   cfg,                           // Channel config
   input  rx_word_t  rd_word,                       // Word from FIFO
   input  logic      rd_valid,                      // Word valid strobe
   output rx_group_t rx_adapt_dout,                 // Assembled group
   output logic      rx_fifo_valid                  // Group done pulse
);

   localparam int W  = `AIB_RX_WORD_W;
   localparam int HW = W / 2;

   logic [1:0] last_idx;                            // Last slot of a group
   logic [1:0] slot;                                // Next free slot
   logic [1:0] k;                                   // Slot for this word
   logic       started;                             // Tagged word seen
   logic       take;                                // Word goes in a slot
   logic       swap;                                // Low word swap active
   rx_group_t  grp;                                 // Partial group
   rx_group_t  grp_nxt;
   rx_group_t  grp_out;                             // Swapped view of grp_nxt

   always_comb begin
      case (cfg.fifo_mode)
         FIFO_2X: last_idx = 2'd1;
         FIFO_4X: last_idx = 2'd3;
         default: last_idx = 2'd0;
      endcase
   end

   assign k    = rd_word.first ? 2'd0 : slot;
   assign take = rd_valid & (started | rd_word.first);
   assign swap = (cfg.fifo_mode == FIFO_2X) & cfg.swap_en & ~cfg.gen2_mode;

   always_comb begin
      grp_nxt    = rd_word.first ? '0 : grp;        // New group clears slots
      grp_nxt[k] = rd_word.data;
      grp_out    = grp_nxt;
      if (swap) begin
         grp_out[0] = {grp_nxt[0][W-1], grp_nxt[0][HW-2:0],
                       grp_nxt[0][HW-1], grp_nxt[0][W-2:HW]};
      end
   end

   // Slot tracking and done pulse
   always_ff @(posedge rxfifo_rd_clk) begin
      if (rst_rd) begin
         slot          <= 2'd0;
         started       <= 1'b0;
         rx_fifo_valid <= 1'b0;
      end else begin
         rx_fifo_valid <= take & (k == last_idx);
         if (take) begin
            started <= 1'b1;
            slot    <= (k == last_idx) ? 2'd0 : k + 2'd1;
         end
      end
   end

   // Data registers
   always_ff @(posedge rxfifo_rd_clk) begin
      if (take) begin
         grp <= grp_nxt;
         if (k == last_idx) begin
            rx_adapt_dout <= grp_out;               // Updates once per group
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/aib_rx_word_align.sv
// ====================
// Word-mark lock on bit 79, tags group starts for the FIFO
// Writes begin on the first marked word after lock
// Lock is held until reset
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_config.svh"

module aib_rx_word_align
   import aib_rx_pkg::*;
(
   input  logic                      rxfifo_wrclk,  // Write clock
   input  logic                      rst,           // Sync reset, active high
   input  rx_cfg_t                   cfg,           // Channel config
   input  logic [`AIB_RX_WORD_W-1:0] dbi_dout,      // Decoded word
   output rx_word_t                  wr_word,       // Word to FIFO
   output logic                      wr_en,         // FIFO write strobe
   output logic                      align_done     // Lock flag, sticky
);

   logic [1:0] last_idx;                            // Group length minus one
   logic [1:0] idx;                                 // Expected slot of this word
   logic [4:0] match_cnt;                           // Good periods in a row
   logic [4:0] cnt_inc;                             // Saturating count + 1
   logic       mark;                                // Mark bit of this word
   logic       mismatch;                            // Mark where not expected
   logic       period_done;                         // Good period ends here
   logic       tag;                                 // Word starts a group
   logic       lock_ok;                             // Writes allowed
   logic       wr_active;                           // First group seen after lock
   logic       wr_go;                               // Write this word

   always_comb begin
      case (cfg.fifo_mode)
         FIFO_2X: last_idx = 2'd1;
         FIFO_4X: last_idx = 2'd3;
         default: last_idx = 2'd0;                  // 1X and register mode
      endcase
   end

   assign mark        = dbi_dout[`AIB_RX_MARK_BIT];
   assign mismatch    = mark ? (idx != 2'd0) : (idx == 2'd0);
   assign period_done = !mismatch && (mark ? (last_idx == 2'd0) : (idx == last_idx));
   assign cnt_inc     = (match_cnt == 5'h1f) ? match_cnt : match_cnt + 5'd1;

   // Without alignment the group phase runs free from reset
   assign tag     = cfg.wa_en ? mark : (idx == 2'd0);
   assign lock_ok = align_done | ~cfg.wa_en;
   assign wr_go   = lock_ok && (wr_active || tag) && (cfg.fifo_mode != REG_MODE);

   // Group phase and lock search
   always_ff @(posedge rxfifo_wrclk) begin
      if (rst) begin
         idx        <= 2'd0;
         match_cnt  <= 5'd0;
         align_done <= 1'b0;
         wr_active  <= 1'b0;
         wr_en      <= 1'b0;
      end else begin
         wr_en     <= wr_go;
         wr_active <= wr_active | (lock_ok & tag);

         if (cfg.wa_en && mark) begin
            idx <= (last_idx == 2'd0) ? 2'd0 : 2'd1; // Mark restarts the period
         end else if (cfg.wa_en && idx == 2'd0) begin
            idx <= 2'd0;                            // Still hunting for a mark
         end else begin
            idx <= (idx == last_idx) ? 2'd0 : idx + 2'd1;
         end

         if (!cfg.wa_en) begin
            align_done <= 1'b1;                     // Bypass, lock right away
         end else if (!align_done) begin
            if (mismatch) begin
               match_cnt <= 5'd0;
            end else if (period_done) begin
               match_cnt <= cnt_inc;
               if (cnt_inc >= cfg.align_threshold) begin
                  align_done <= 1'b1;
               end
            end
         end
      end
   end

   // Payload stage, no reset
   always_ff @(posedge rxfifo_wrclk) begin
      wr_word.data  <= dbi_dout;
      wr_word.first <= tag;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
rtl/aib_rx_pkg.sv
rtl/aib_rx_dbi.sv
rtl/aib_rx_word_align.sv
rtl/aib_rx_phcomp_fifo.sv
rtl/aib_rx_rd_assemble.sv
rtl/aib_adapter_rxchnl.sv
verification/aib_rx_assert.sv
verification/aib_rx_tb.sv

//--- verification/aib_rx_assert.sv
// ====================
// Protocol checks bound to the receive channel top level
// ====================

`timescale 1ns/1ps
`default_nettype none

module aib_rx_assert (
   input logic rxfifo_wrclk,                        // Write clock
   input logic rxfifo_rd_clk,                       // Read clock
   input logic rst,                                 // Write-domain reset
   input logic rst_rd,                              // Read-domain reset
   input logic align_done,
   input logic fifo_overflow,
   input logic rx_fifo_valid
);

   // Lock is sticky once reset is over
   align_sticky: assert property (@(posedge rxfifo_wrclk)
      (!rst && !$past(rst)) |-> !$fell(align_done))
      else $error("align_done dropped outside reset");

   // Read rate matches write rate, no word may be lost
   no_overflow: assert property (@(posedge rxfifo_wrclk) disable iff (rst)
      !$rose(fifo_overflow))
      else $error("fifo_overflow was raised");

   // No group strobe while the read side is in reset
   valid_in_reset: assert property (@(posedge rxfifo_rd_clk)
      $past(rst_rd) |-> !rx_fifo_valid)
      else $error("rx_fifo_valid high during reset");

endmodule

bind aib_adapter_rxchnl aib_rx_assert rx_assert (
   .rxfifo_wrclk  (rxfifo_wrclk),
   .rxfifo_rd_clk (rxfifo_rd_clk),
   .rst           (rst),
   .rst_rd        (rst_rd),
   .align_done    (align_done),
   .fifo_overflow (fifo_overflow),
   .rx_fifo_valid (rx_fifo_valid)
);

`default_nettype wire

//--- include/aib_rx_tb_config.svh
// ====================
// Testbench limits, sized from the test lengths
// ====================

`ifndef AIB_RX_TB_CONFIG_SVH
`define AIB_RX_TB_CONFIG_SVH

// Words driven over all tests, trailing idle words included
`define AIB_RX_TB_TOTAL_WORDS (2*66 + 45 + 2*44 + 2*164 + 3*84)

// Cycle limit on the write clock
`define AIB_RX_TB_CYCLE_LIMIT (`AIB_RX_TB_TOTAL_WORDS * 4 + 200)

`endif

//--- verification/aib_rx_tb.sv
// ====================
// Receive channel testbench, two 4 ns clocks 1.3 ns apart
// FIFO tests run with DBI off, since bit 79 is both mark and lane flag
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_config.svh"
`include "aib_rx_tb_config.svh"

module aib_rx_tb
   import aib_rx_pkg::*;
;

   logic                      rxfifo_wrclk;
   logic                      rxfifo_rd_clk;
   logic                      rst;
   rx_cfg_t                   cfg;
   logic [`AIB_RX_WORD_W-1:0] din;
   logic [`AIB_RX_WORD_W-1:0] data_out;
   rx_group_t                 rx_adapt_dout;
   logic                      rx_fifo_valid;
   logic                      align_done;
   logic                      fifo_overflow;

   integer    seed = 50;
   integer    cycles = 0;
   integer    word_cnt;                             // Words driven in this test
   integer    align_first;                          // word_cnt when lock seen
   integer    test_err, n_pass = 0, n_fail = 0;
   integer    pushed, got;                          // Groups expected, received
   string     cur_name;
   rx_group_t exp_q[$];                             // Expected groups

   logic [`AIB_RX_WORD_W-1:0] din_q;                // din as seen by the DUT
   logic      dbi_flag, dbi_flag_q;                 // Check data_out
   logic      fifo_flag, fifo_flag_q;               // Word belongs to a test group
   logic      exp_swap;                             // Low word swap expected
   logic      grp_chk;                              // Count stray groups
   logic      mon_active;
   integer    mon_slot;
   rx_group_t mon_raw;

   aib_adapter_rxchnl aib_adapter_rxchnl_i (
      .rxfifo_wrclk (rxfifo_wrclk), .rxfifo_rd_clk (rxfifo_rd_clk),
      .rst (rst), .cfg (cfg), .din (din), .data_out (data_out),
      .rx_adapt_dout (rx_adapt_dout), .rx_fifo_valid (rx_fifo_valid),
      .align_done (align_done), .fifo_overflow (fifo_overflow)
   );

   initial begin
      rxfifo_wrclk = 1'b0;
      forever #2 rxfifo_wrclk = ~rxfifo_wrclk;
   end

   initial begin
      rxfifo_rd_clk = 1'b0;
      #1.3;                                         // Phase offset
      forever #2 rxfifo_rd_clk = ~rxfifo_rd_clk;
   end

   // Lane rule, flag set means payload was sent inverted
   function automatic logic [79:0] ref_dbi(input logic [79:0] w, input logic en);
      logic [79:0] r;
      r = w;
      for (int l = 0; l < 4; l++) begin
         if (en && w[l*20+19]) begin
            r[l*20 +: 20] = {1'b0, ~w[l*20 +: 19]};
         end
      end
      return r;
   endfunction

   function automatic integer group_len(input rx_fifo_mode_e m);
      return (m == FIFO_2X) ? 2 : (m == FIFO_4X) ? 4 : 1;
   endfunction

   // Slot k gets word k, upper slots zero, gen1 2X swaps the low word
   function automatic rx_group_t ref_group(input rx_group_t raw, input integer n,
                                           input logic do_swap);
      rx_group_t g;
      logic [79:0] w;
      g = '0;
      for (int k = 0; k < n; k++) begin
         g[k] = raw[k];
      end
      w = g[0];
      if (do_swap) begin
         g[0] = {w[79], w[38:0], w[39], w[78:40]};
      end
      return g;
   endfunction

   task automatic make_word(input logic mark, output logic [79:0] w);
      w = {16'($random(seed)), $random(seed), $random(seed)};
      w[79] = mark;                                 // Word-mark bit
   endtask

   task automatic drive_word(input logic [79:0] w);
      @(posedge rxfifo_wrclk);
      #0.5;
      din = w;
      word_cnt = word_cnt + 1;
   endtask

   task automatic apply_reset();
      @(posedge rxfifo_wrclk);
      #0.5 rst = 1'b1;
      repeat (4) @(posedge rxfifo_wrclk);
      #0.5 rst = 1'b0;
      word_cnt = 0;
      align_first = 0;
   endtask

   task automatic begin_test(input string name);
      cur_name = name;
      test_err = 0;
   endtask

   task automatic end_test();
      if (test_err == 0) begin
         $display("test %s: passed", cur_name);
         n_pass++;
      end else begin
         $display("test %s: %0d errors", cur_name, test_err);
         n_fail++;
      end
   endtask

   task automatic check_idle(input string when);
      @(negedge rxfifo_wrclk);
      assert (align_done == 1'b0 && rx_fifo_valid == 1'b0 && fifo_overflow == 1'b0)
      else begin
         $display("FAILED %s: status outputs not low %s", cur_name, when);
         test_err++;
      end
   endtask

   task automatic run_reset_test();
      begin_test("reset_state");
      cfg = '0;
      cfg.fifo_mode = REG_MODE;
      cfg.wa_en = 1'b1;
      din = '0;
      @(posedge rxfifo_wrclk);
      #0.5 rst = 1'b1;
      repeat (3) @(posedge rxfifo_wrclk);
      check_idle("during reset");
      @(posedge rxfifo_wrclk);
      #0.5 rst = 1'b0;
      check_idle("after reset");
      check_idle("after reset");
      end_test();
   endtask

   task automatic run_dbi_test(input string name, input logic en);
      logic [79:0] w;
      begin_test(name);
      cfg = '0;
      cfg.fifo_mode = REG_MODE;
      cfg.dbi_en = en;
      apply_reset();
      dbi_flag = 1'b1;
      for (int i = 0; i < 64; i++) begin
         make_word(1'($random(seed)), w);           // Random mark bit too
         drive_word(w);
      end
      drive_word('0);
      dbi_flag = 1'b0;                              // Last word still checked
      drive_word('0);
      end_test();
   endtask

   task automatic run_align_test();
      logic [79:0] w;
      begin_test("align_threshold_5");
      cfg = '0;
      cfg.fifo_mode = FIFO_2X;
      cfg.wa_en = 1'b1;
      cfg.align_threshold = 5'd5;
      apply_reset();
      for (int r = 0; r < 3; r++) begin            // 4 good periods, then a bad word
         for (int p = 0; p < 8; p++) begin
            make_word(p % 2 == 0, w);
            drive_word(w);
         end
         make_word(1'b0, w);
         drive_word(w);
      end
      for (int p = 0; p < 18; p++) begin           // 5 good periods and spare
         make_word(p % 2 == 0, w);
         drive_word(w);
      end
      assert (align_first == 27 + 10 + 2)
      else begin
         $display("FAILED %s: lock word expected %0d actual %0d",
                  cur_name, 27 + 10 + 2, align_first);
         test_err++;
      end
      end_test();
   endtask

   task automatic run_fifo_test(input string name, input rx_fifo_mode_e mode,
                                input logic [3:0] dly, input logic sw, input logic g2,
                                input logic exp_sw);
      logic [79:0] w;
      integer n;
      begin_test(name);
      n = group_len(mode);
      cfg = '0;
      cfg.fifo_mode = mode;
      cfg.wa_en = 1'b1;
      cfg.align_threshold = 5'd2;
      cfg.rd_delay = dly;
      cfg.swap_en = sw;
      cfg.gen2_mode = g2;
      exp_swap = exp_sw;
      apply_reset();
      pushed = 0;
      got = 0;
      grp_chk = 1'b1;
      fifo_flag = 1'b1;
      for (int g = 0; g < 40; g++) begin
         for (int k = 0; k < n; k++) begin
            make_word(k == 0, w);
            drive_word(w);
         end
      end
      drive_word('0);
      fifo_flag = 1'b0;                             // Last group still pushed
      repeat (3) drive_word('0);
      while (exp_q.size() > 0) begin
         @(posedge rxfifo_wrclk);
      end
      repeat (8) @(posedge rxfifo_wrclk);           // Room for a stray last group
      #0.5;
      grp_chk = 1'b0;
      assert (got == pushed && pushed >= 36)
      else begin
         $display("FAILED %s: group count expected %0d actual %0d", cur_name, pushed, got);
         test_err++;
      end
      end_test();
   endtask

   always @(posedge rxfifo_wrclk) begin
      din_q       <= din;
      dbi_flag_q  <= dbi_flag;
      fifo_flag_q <= fifo_flag;
      cycles      <= cycles + 1;
      if (cycles >= `AIB_RX_TB_CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", `AIB_RX_TB_CYCLE_LIMIT);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // Write-side monitor, mirrors the word the aligner sees this cycle
   always @(negedge rxfifo_wrclk) begin
      logic [79:0] w;
      w = ref_dbi(din_q, cfg.dbi_en);
      if (rst) begin
         mon_active = 1'b0;
         mon_slot   = 0;
      end else begin
         if (align_done && align_first == 0) begin
            align_first = word_cnt;
         end
         if (dbi_flag_q) begin
            assert (data_out == w)
            else begin
               $display("FAILED %s: expected %h actual %h", cur_name, w, data_out);
               test_err++;
            end
         end
         if (align_done && cfg.fifo_mode != REG_MODE && (mon_active || w[79])) begin
            mon_active = 1'b1;
            if (w[79]) begin                        // Group start
               mon_slot = 0;
               mon_raw  = '0;
            end
            mon_raw[mon_slot] = w;
            if (mon_slot == group_len(cfg.fifo_mode) - 1) begin
               if (fifo_flag_q) begin
                  exp_q.push_back(ref_group(mon_raw, group_len(cfg.fifo_mode), exp_swap));
                  pushed++;
               end
               mon_slot = 0;
            end else begin
               mon_slot++;
            end
         end
      end
   end

   // Read-side comparator, zero groups past the expected ones are idle fill
   always @(negedge rxfifo_rd_clk) begin
      rx_group_t e;
      if (rx_fifo_valid === 1'b1) begin
         if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            got++;
            assert (rx_adapt_dout == e)
            else begin
               $display("FAILED %s: expected %h actual %h", cur_name, e, rx_adapt_dout);
               test_err++;
            end
         end else if (grp_chk && rx_adapt_dout != '0) begin
            got++;                                  // Data group nobody sent
         end
      end
   end

   initial begin
      rst = 1'b1;
      cfg = '0;
      din = '0;
      dbi_flag = 1'b0;
      fifo_flag = 1'b0;
      exp_swap = 1'b0;
      grp_chk = 1'b0;
      word_cnt = 0;
      align_first = 0;
      run_reset_test();
      run_dbi_test("dbi_off", 1'b0);
      run_dbi_test("dbi_on", 1'b1);
      run_align_test();
      run_fifo_test("fifo_1x_delay2", FIFO_1X, 4'd2, 1'b0, 1'b0, 1'b0);
      run_fifo_test("fifo_1x_delay6", FIFO_1X, 4'd6, 1'b0, 1'b0, 1'b0);
      run_fifo_test("fifo_4x_delay2", FIFO_4X, 4'd2, 1'b0, 1'b0, 1'b0);
      run_fifo_test("fifo_4x_delay6", FIFO_4X, 4'd6, 1'b0, 1'b0, 1'b0);
      run_fifo_test("fifo_2x_swap_gen1", FIFO_2X, 4'd2, 1'b1, 1'b0, 1'b1);
      run_fifo_test("fifo_2x_swap_gen2", FIFO_2X, 4'd2, 1'b1, 1'b1, 1'b0);
      run_fifo_test("fifo_2x_noswap", FIFO_2X, 4'd2, 1'b0, 1'b0, 1'b0);
      $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
      if (n_fail == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
